// ==== player_top.f ====
player_pkg.sv
collide_if.sv
motion_if.sv
platform_collide.sv
player_move_ctrl.sv
sprite_anim.sv
player_top.sv
player_assert.sv
player_tb.sv

// ==== player_tb.sv ====
// random buttons come from a fixed seed; every cycle is checked against the cycle model below
`timescale 1ns/1ps
`default_nettype none

module player_tb import player_pkg::*; ();

    localparam int CYCLE_LIMIT = 20000;   // scripted phases, 4000 random cycles, margin
    localparam int RAND_CYCLES = 4000;

    logic       clk, rst, left, right, jump;
    logic [9:0] x, y;
    logic [6:0] sprite;
    int         cycles;

    // model registers
    logic [9:0]    m_x, m_y, m_ystart;
    logic [3:0]    m_hcnt, m_vcnt, m_vint;
    logic [6:0]    m_sprite;
    logic          m_spawned, m_facing, m_xstep, m_xal, m_spawn;
    motion_state_t m_state;

    player_top player_top_inst (
        .clk(clk), .rst(rst), .left(left), .right(right), .jump(jump),
        .x(x), .y(y), .sprite(sprite)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: stimulus did not finish");
        $display("CHECKS FAILED");
        $fatal(1, "cycle limit reached");
    end

    // --------------------
    // compare tasks
    task automatic check_pos(input string what, input logic [9:0] got, input logic [9:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, what, exp, got);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_sprite(input logic [6:0] got, input logic [6:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: sprite expected %b, got %b", $time, exp, got);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_state(input motion_state_t got, input motion_state_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: state expected %s, got %s", $time, exp.name(), got.name());
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // --------------------
    // collision rules from the platform table
    function automatic logic ground_at(input int qx, input int qy);
        logic hit;
        hit = (qy + PLAYER_H == FLOOR_Y);
        for (int i = 0; i < NUM_PLATFORMS; i++)
            if (qx + PLAYER_W - 1 >= PLAT_X0[i] && qx <= PLAT_X1[i] && qy + PLAYER_H == PLAT_Y[i])
                hit = 1'b1;
        return hit;
    endfunction

    function automatic logic ceiling_at(input int qx, input int qy);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_PLATFORMS; i++)
            if (qx + PLAYER_W - 1 >= PLAT_X0[i] && qx <= PLAT_X1[i] && qy == PLAT_Y[i] + 4)
                hit = 1'b1;
        return hit;
    endfunction

    // one clock of the reference model, buttons as sampled on the rising edge
    task automatic model_cycle(input logic l, input logic r, input logic j);
        logic          gr, gl, one, air;
        logic [9:0]    xn, yn, rise;
        logic [3:0]    hn, vcn, vin;
        logic [6:0]    spn;
        motion_state_t sn;
        air = (m_state == JUMPING) || (m_state == FALLING);
        spn = m_sprite;                                   // built from last cycle's fields
        spn[SPRITE_FACING] = m_facing;
        spn[SPRITE_AIR]    = air;
        spn[SPRITE_IDLE]   = (m_state == IDLE);
        if (m_xstep && (air || m_xal))
            spn[3:0] = {1'b0, m_sprite[2:0] + 3'd1};
        if (m_spawn) begin
            spn = '0;
            spn[SPRITE_FACING] = 1'b1;
            spn[SPRITE_IDLE]   = 1'b1;
        end
        m_sprite = spn;
        if (!m_spawned) begin
            m_x = SPAWN_X;
            m_y = SPAWN_Y;
            m_spawned = 1'b1;
            m_spawn = 1'b1;
        end else begin
            gr  = r && !l;
            gl  = l && !r;
            one = gr || gl;
            xn  = m_x;
            hn  = '0;
            if (one && (air || !j)) begin
                if (int'(m_hcnt) + 1 >= int'(air ? AIR_STEP : GROUND_STEP)) begin
                    if (gr && m_x < FIELD_W - PLAYER_W)
                        xn = m_x + 10'd1;
                    if (gl && m_x > 0)
                        xn = m_x - 10'd1;
                end else begin
                    hn = m_hcnt + 4'd1;
                end
            end
            yn  = m_y;
            vcn = '0;
            vin = RISE_START;
            sn  = m_state;
            if (air) begin
                vcn = m_vcnt + 4'd1;
                vin = m_vint;
                if (int'(m_vcnt) + 1 >= int'(m_vint)) begin
                    vcn = '0;
                    if (m_state == JUMPING && m_y > 0)
                        yn = m_y - 10'd1;
                    if (m_state == FALLING && m_y < FLOOR_Y - PLAYER_H)
                        yn = m_y + 10'd1;
                    rise = m_ystart - yn;
                    if (m_state == FALLING)
                        vin = (m_vint > FALL_MIN) ? m_vint - 4'd1 : FALL_MIN;
                    else if (rise > APEX_ZONE)
                        vin = (m_vint < RISE_MAX) ? m_vint + 4'd1 : RISE_MAX;
                end
            end
            rise = m_ystart - yn;
            if (m_state == JUMPING) begin
                if (rise >= JUMP_HEIGHT || ceiling_at(xn, yn)) begin
                    sn  = FALLING;                        // fall starts at the rise interval
                    vcn = '0;
                end
            end else if (m_state == FALLING) begin
                if (ground_at(xn, yn)) begin
                    sn  = IDLE;
                    vcn = '0;
                end
            end else begin
                m_ystart = m_y;
                if (j) begin
                    sn = JUMPING;
                end else if (!ground_at(xn, yn)) begin
                    sn  = FALLING;                        // off an edge
                    vin = FALL_START_DEFAULT;
                end else begin
                    sn = one ? MOVING : IDLE;
                end
            end
            m_xstep = (xn != m_x);
            m_xal   = (m_x[2:0] == 3'd0);
            m_spawn = 1'b0;
            if (one)
                m_facing = gr;
            m_x = xn;
            m_y = yn;
            m_state = sn;
            m_hcnt = hn;
            m_vcnt = vcn;
            m_vint = vin;
        end
    endtask

    // --------------------
    // stimulus, entered and left on a falling edge
    task automatic run_cycle(input logic l, input logic r, input logic j);
        left  = l;
        right = r;
        jump  = j;
        @(posedge clk);
        model_cycle(l, r, j);
        @(negedge clk);
        check_pos("x", x, m_x);
        check_pos("y", y, m_y);
        check_sprite(sprite, m_sprite);
        check_state(player_top_inst.mot_bus.state, m_state);
        if (player_top_inst.player_move_ctrl_inst.player_assert_inst.fails != 0) begin
            $display("a bound assertion failed at %0t", $time);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first assertion failure");
        end
    endtask

    task automatic hold_buttons(input logic l, input logic r, input logic j, input int n);
        repeat (n) run_cycle(l, r, j);
    endtask

    task automatic wait_landed();
        while (player_top_inst.mot_bus.state != IDLE)
            run_cycle(1'b0, 1'b0, 1'b0);
    endtask

    initial begin
        logic [9:0] x0, y0, y_top;
        logic [2:0] btn;
        int         len, done;
        void'($urandom(8496));
        rst = 1'b1;
        left = 1'b0;
        right = 1'b0;
        jump = 1'b0;
        {m_x, m_y, m_ystart, m_hcnt, m_vcnt, m_sprite} = '0;
        {m_spawned, m_xstep, m_xal, m_spawn} = '0;
        m_vint = RISE_START;
        m_facing = 1'b1;
        m_state = IDLE;
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_pos("x in reset", x, '0);
        check_pos("y in reset", y, '0);
        check_sprite(sprite, '0);
        rst = 1'b0;

        // spawn
        run_cycle(1'b0, 1'b0, 1'b0);
        check_pos("spawn x", x, SPAWN_X);
        check_pos("spawn y", y, SPAWN_Y);
        check_state(player_top_inst.mot_bus.state, IDLE);
        hold_buttons(1'b0, 1'b0, 1'b0, 3);

        // walk right, then a short left tap turns the sprite around
        x0 = x;
        hold_buttons(1'b0, 1'b1, 1'b0, 40);
        check_pos("walk x", x, x0 + 10'(40 / GROUND_STEP));
        hold_buttons(1'b1, 1'b0, 1'b0, 2);
        hold_buttons(1'b0, 1'b0, 1'b0, 2);

        // jump from standing, full height, land on the same line
        y0 = y;
        run_cycle(1'b0, 1'b0, 1'b1);
        y_top = y;
        while (player_top_inst.mot_bus.state != IDLE) begin
            run_cycle(1'b0, 1'b0, 1'b0);
            if (y < y_top)
                y_top = y;
        end
        check_pos("apex y", y_top, y0 - 10'(JUMP_HEIGHT));
        check_pos("landing y", y, y0);

        // off the left edge of platform 0 down to the floor
        while (player_top_inst.mot_bus.state != FALLING)
            run_cycle(1'b1, 1'b0, 1'b0);
        wait_landed();
        check_pos("floor y", y, 10'(FLOOR_Y - PLAYER_H));

        // both playfield edges
        hold_buttons(1'b1, 1'b0, 1'b0, 400);
        check_pos("left clamp", x, '0);
        hold_buttons(1'b0, 1'b1, 1'b0, 4100);
        check_pos("right clamp", x, 10'(FIELD_W - PLAYER_W));

        // random runs, left and right together included
        done = 0;
        while (done < RAND_CYCLES) begin
            btn = 3'($urandom % 8);
            len = 1 + int'($urandom % 60);
            hold_buttons(btn[2], btn[1], btn[0], len);
            done += len;
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== player_assert.sv ====
// bound into the movement controller; the x step rule starts two cycles after reset, past spawn
`timescale 1ns/1ps
`default_nettype none

module player_assert import player_pkg::*; (
    input logic          clk,
    input logic          rst,
    input logic [9:0]    x,
    input logic [9:0]    y,
    input motion_state_t state
);

    int fails = 0;   // failed assertions so far

    // --------------------
    x_in_field: assert property (@(posedge clk) disable iff (rst) x <= 10'(FIELD_W - PLAYER_W))
        else begin fails++; $error("x left the playfield"); end

    y_in_field: assert property (@(posedge clk) disable iff (rst) y <= 10'(FLOOR_Y - PLAYER_H))
        else begin fails++; $error("y left the playfield"); end

    state_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(state))
        else begin fails++; $error("state is unknown"); end

    // walking never skips a pixel
    x_single_step: assert property (@(posedge clk) disable iff (rst)
        !$past(rst, 2) |-> (x == $past(x)) || (x == $past(x) + 10'd1) || (x + 10'd1 == $past(x)))
        else begin fails++; $error("x moved by more than one pixel"); end

endmodule

bind player_move_ctrl player_assert player_assert_inst (
    .clk(clk), .rst(rst), .x(x), .y(y), .state(state)
);

`default_nettype wire

// ==== player_top.sv ====
// buttons must already be synchronous to clk; x, y and sprite go straight to the renderer
`timescale 1ns/1ps
`default_nettype none

module player_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       left,
    input  logic       right,
    input  logic       jump,
    output logic [9:0] x,
    output logic [9:0] y,
    output logic [6:0] sprite
);

    collide_if col_bus ();
    motion_if  mot_bus ();

    player_move_ctrl player_move_ctrl_inst (
        .clk   (clk),
        .rst   (rst),
        .left  (left),
        .right (right),
        .jump  (jump),
        .x     (x),
        .y     (y),
        .col   (col_bus.ctrl),
        .mot   (mot_bus.src)
    );

    platform_collide platform_collide_inst (
        .col (col_bus.check)
    );

    sprite_anim sprite_anim_inst (
        .clk    (clk),
        .rst    (rst),
        .mot    (mot_bus.anim),
        .sprite (sprite)
    );

endmodule

`default_nettype wire

// ==== sprite_anim.sv ====
// frames run 0 to 7 only; the sprite word trails the motion fields by one clock
`timescale 1ns/1ps
`default_nettype none

module sprite_anim import player_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    motion_if.anim     mot,
    output logic [6:0] sprite
);

    logic       in_air;
    logic       advance;
    logic [2:0] frame_inc;
    logic [6:0] sprite_nxt;

    assign in_air    = (mot.state == JUMPING) || (mot.state == FALLING);
    assign advance   = mot.x_step && (in_air || mot.x_aligned);   // ground waits for aligned x
    assign frame_inc = sprite[2:0] + 3'd1;                        // wraps at 8

    always_comb begin
        sprite_nxt                = sprite;
        sprite_nxt[SPRITE_FACING] = mot.facing_right;
        sprite_nxt[SPRITE_AIR]    = in_air;
        sprite_nxt[SPRITE_IDLE]   = (mot.state == IDLE);
        if (advance)
            sprite_nxt[3:0] = {1'b0, frame_inc};
        if (mot.spawn) begin
            sprite_nxt                = '0;                       // frame 0, on the ground
            sprite_nxt[SPRITE_FACING] = 1'b1;
            sprite_nxt[SPRITE_IDLE]   = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            sprite <= '0;
        else
            sprite <= sprite_nxt;
    end

endmodule

`default_nettype wire

// ==== player_move_ctrl.sv ====
// inputs are used as plain levels without debouncing; left and right together count as no direction
`timescale 1ns/1ps
`default_nettype none

module player_move_ctrl import player_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       left,
    input  logic       right,
    input  logic       jump,
    output logic [9:0] x,
    output logic [9:0] y,
    collide_if.ctrl    col,
    motion_if.src      mot
);

    motion_state_t     state, state_nxt;
    logic              spawned;
    logic [9:0]        x_nxt, y_nxt;
    logic [9:0]        y_jump_start, y_jump_start_nxt;
    logic [9:0]        rise;                          // height above the jump start
    logic [PACE_W-1:0] hcnt, hcnt_nxt;                // horizontal pacing
    logic [PACE_W-1:0] vcnt, vcnt_run, vcnt_nxt;      // vertical pacing
    logic [PACE_W-1:0] vint, vint_run, vint_nxt;      // current vertical interval
    logic              go_right, go_left, one_dir;
    logic              airborne;
    logic              h_due, v_due;
    logic              x_moved;

    assign go_right = right && !left;
    assign go_left  = left && !right;
    assign one_dir  = go_right || go_left;
    assign airborne = (state == JUMPING) || (state == FALLING);

    assign h_due = airborne ? (hcnt >= AIR_STEP - 1'b1) : (hcnt >= GROUND_STEP - 1'b1);
    assign v_due = (vcnt >= vint - 1'b1);

    // --------------------
    // horizontal step with clamping
    always_comb begin
        x_nxt    = x;
        hcnt_nxt = '0;                                 // released or jump from ground
        if (one_dir && (airborne || !jump)) begin
            if (h_due) begin
                if (go_right && (x < 10'(FIELD_W - PLAYER_W)))
                    x_nxt = x + 1'b1;
                else if (go_left && (x != '0))
                    x_nxt = x - 1'b1;
            end else begin
                hcnt_nxt = hcnt + 1'b1;
            end
        end
    end

    assign x_moved = (x_nxt != x);

    // --------------------
    // vertical step, rise slows past the apex zone and the fall speeds up
    always_comb begin
        y_nxt    = y;
        vcnt_run = '0;
        vint_run = RISE_START;
        rise     = y_jump_start - y;
        case (state)
            JUMPING: begin
                vcnt_run = vcnt + 1'b1;
                vint_run = vint;
                if (v_due) begin
                    vcnt_run = '0;
                    if (y != '0)
                        y_nxt = y - 1'b1;
                    rise = y_jump_start - y_nxt;
                    if (rise > 10'(APEX_ZONE))
                        vint_run = (vint >= RISE_MAX) ? RISE_MAX : vint + 1'b1;
                end
            end
            FALLING: begin
                vcnt_run = vcnt + 1'b1;
                vint_run = vint;
                if (v_due) begin
                    vcnt_run = '0;
                    if (y < 10'(FLOOR_Y - PLAYER_H))
                        y_nxt = y + 1'b1;
                    vint_run = (vint <= FALL_MIN) ? FALL_MIN : vint - 1'b1;
                end
            end
            default: ;                                 // on the ground y holds
        endcase
    end

    // candidate position goes to the checker
    assign col.qx = x_nxt;
    assign col.qy = y_nxt;

    // --------------------
    // state transitions
    always_comb begin
        state_nxt        = state;
        vcnt_nxt         = vcnt_run;
        vint_nxt         = vint_run;
        y_jump_start_nxt = y_jump_start;
        case (state)
            JUMPING: begin
                if ((rise >= 10'(JUMP_HEIGHT)) || col.hit_ceiling) begin
                    state_nxt = FALLING;               // keeps the rise interval
                    vcnt_nxt  = '0;
                end
            end
            FALLING: begin
                if (col.on_ground) begin
                    state_nxt = IDLE;                  // lands on this step
                    vcnt_nxt  = '0;
                end
            end
            default: begin
                y_jump_start_nxt = y;
                if (jump) begin
                    state_nxt = JUMPING;
                end else if (!col.on_ground) begin
                    state_nxt = FALLING;               // walked off an edge
                    vint_nxt  = FALL_START_DEFAULT;
                end else if (one_dir) begin
                    state_nxt = MOVING;
                end else begin
                    state_nxt = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            x                <= '0;
            y                <= '0;
            state            <= IDLE;
            spawned          <= 1'b0;
            hcnt             <= '0;
            vcnt             <= '0;
            vint             <= RISE_START;
            y_jump_start     <= '0;
            mot.facing_right <= 1'b1;
            mot.x_step       <= 1'b0;
            mot.x_aligned    <= 1'b0;
            mot.spawn        <= 1'b0;
        end else if (!spawned) begin
            x         <= SPAWN_X;                      // first cycle out of reset
            y         <= SPAWN_Y;
            spawned   <= 1'b1;
            mot.spawn <= 1'b1;
        end else begin
            x             <= x_nxt;
            y             <= y_nxt;
            state         <= state_nxt;
            hcnt          <= hcnt_nxt;
            vcnt          <= vcnt_nxt;
            vint          <= vint_nxt;
            y_jump_start  <= y_jump_start_nxt;
            mot.x_step    <= x_moved;
            mot.x_aligned <= (x[2:0] == 3'd0);
            mot.spawn     <= 1'b0;
            if (one_dir)
                mot.facing_right <= go_right;
        end
    end

    assign mot.state = state;

endmodule

`default_nettype wire

// ==== platform_collide.sv ====
// exact line matches only; the candidate must move by at most one pixel per cycle to be caught
`timescale 1ns/1ps
`default_nettype none

module platform_collide import player_pkg::*; (
    collide_if.check col
);

    logic [10:0]              box_bottom;   // first row under the box
    logic [10:0]              box_right;    // rightmost column of the box
    logic [NUM_PLATFORMS-1:0] x_overlap;
    logic [NUM_PLATFORMS-1:0] on_top;
    logic [NUM_PLATFORMS-1:0] under;
    logic                     on_floor;

    assign box_bottom = {1'b0, col.qy} + 11'(PLAYER_H);
    assign box_right  = {1'b0, col.qx} + 11'(PLAYER_W - 1);

    // --------------------
    // per platform tests
    always_comb begin
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            x_overlap[i] = (box_right >= {1'b0, PLAT_X0[i]}) && (col.qx <= PLAT_X1[i]);

            // feet exactly on the top line
            on_top[i] = x_overlap[i] && (box_bottom == {1'b0, PLAT_Y[i]});

            // head just below the underside
            under[i] = x_overlap[i] && (col.qy == PLAT_Y[i] + 10'(PLAT_THICK));
        end
    end

    assign on_floor = (box_bottom == 11'(FLOOR_Y));   // floor spans the whole width

    assign col.on_ground   = (|on_top) || on_floor;
    assign col.hit_ceiling = |under;

endmodule

`default_nettype wire

// ==== motion_if.sv ====
// all fields are registered in the movement controller; x_step and spawn are single-cycle pulses
`timescale 1ns/1ps
`default_nettype none

interface motion_if import player_pkg::*; ();

    motion_state_t state;
    logic          facing_right;   // last pressed direction
    logic          x_step;         // x changed on the last edge
    logic          x_aligned;      // x mod 8 was 0 before that step
    logic          spawn;

    // --------------------
    modport src (output state, facing_right, x_step, x_aligned, spawn);

    modport anim (input state, facing_right, x_step, x_aligned, spawn);

endinterface

`default_nettype wire

// ==== collide_if.sv ====
// purely combinational query; the answer is valid in the same cycle as the candidate
`timescale 1ns/1ps
`default_nettype none

interface collide_if ();

    logic [9:0] qx;            // candidate left edge
    logic [9:0] qy;            // candidate top edge
    logic       on_ground;
    logic       hit_ceiling;

    // movement controller side
    modport ctrl (output qx, qy, input on_ground, hit_ceiling);

    // platform checker side
    modport check (input qx, qy, output on_ground, hit_ceiling);

endinterface

`default_nettype wire

// ==== player_pkg.sv ====
// fixed 1024x768 field and a fixed platform table; step intervals are sized for short simulations
`default_nettype none

package player_pkg;

    // --------------------
    // playfield and player box
    localparam int FIELD_W  = 1024;
    localparam int FIELD_H  = 768;
    localparam int PLAYER_W = 16;
    localparam int PLAYER_H = 24;
    localparam int FLOOR_Y  = FIELD_H - 1;   // floor line, 767

    // --------------------
    // platform table
    localparam int NUM_PLATFORMS = 3;
    localparam int PLAT_THICK    = 4;         // rows below the top line
    localparam logic [9:0] PLAT_X0 [NUM_PLATFORMS] = '{10'd96, 10'd288, 10'd608};
    localparam logic [9:0] PLAT_X1 [NUM_PLATFORMS] = '{10'd351, 10'd543, 10'd863};
    localparam logic [9:0] PLAT_Y  [NUM_PLATFORMS] = '{10'd600, 10'd548, 10'd720};

    // spawn stands on platform 0
    localparam logic [9:0] SPAWN_X = 10'd160;
    localparam logic [9:0] SPAWN_Y = PLAT_Y[0] - 10'(PLAYER_H);

    localparam int JUMP_HEIGHT = 40;   // max rise in pixels
    localparam int APEX_ZONE   = 30;   // rise where slowing starts

    // --------------------
    // pacing, in clock cycles
    localparam int PACE_W = 4;
    localparam logic [PACE_W-1:0] GROUND_STEP        = PACE_W'(4);
    localparam logic [PACE_W-1:0] AIR_STEP           = PACE_W'(6);
    localparam logic [PACE_W-1:0] RISE_START         = PACE_W'(2);
    localparam logic [PACE_W-1:0] RISE_MAX           = PACE_W'(8);
    localparam logic [PACE_W-1:0] FALL_START_DEFAULT = PACE_W'(8);
    localparam logic [PACE_W-1:0] FALL_MIN           = PACE_W'(1);

    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        MOVING  = 2'b01,
        JUMPING = 2'b11,
        FALLING = 2'b10
    } motion_state_t;

    // sprite word {facing, air, idle, frame[3:0]}
    localparam int SPRITE_FACING = 6;
    localparam int SPRITE_AIR    = 5;
    localparam int SPRITE_IDLE   = 4;

endpackage

`default_nettype wire
